//--- Bender.yml
package:
  name: sme

sources:
  - common/sme_pkg.sv
  - verilog/sme_char_store.sv
  - verilog/sme_loader.sv
  - matcher/sme_matcher.sv
  - verilog/sme_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/sme_tb.sv

//--- bench/sme_tb_tasks.svh
task automatic check(input logic [31:0] actual, input logic [31:0] expected, input string what);
    if (actual !== expected)
    begin
        $display("Fail at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
        $display("Simulation FAILED");
        $fatal(1);
    end
endtask

// smallest matching start position, or -1
function automatic int model_match();
    int p;
    int k;
    bit ok;
    for (p = 0; p < mdl_len; p++)
    begin
        ok = 1'b1;
        for (k = 0; k < mdl_plen; k++)
        begin
            if (p + k >= mdl_len)
                ok = 1'b0;
            else if (mdl_pat[k] != WILDCARD && mdl_pat[k] != mdl_str[p + k])
                ok = 1'b0;
        end
        if (mdl_head && p != 0 && mdl_str[p - 1] != SEPARATOR)
            ok = 1'b0;
        // window running past the end already failed above
        if (mdl_tail && p + mdl_plen < mdl_len && mdl_str[p + mdl_plen] != SEPARATOR)
            ok = 1'b0;
        if (ok)
            return p;
    end
    return -1;
endfunction

task automatic run_job(input bit new_str, input string s, input string pat);
    int i;
    int waited;
    int exp_idx;
    if (new_str)
    begin
        mdl_len = 0;
        for (i = 0; i < s.len(); i++)
        begin
            @(negedge clk);
            isstring = 1'b1;
            chardata = s[i];
            mdl_str[i] = s[i];
            mdl_len++;
        end
    end
    mdl_plen = 0;
    mdl_head = 1'b0;
    mdl_tail = 1'b0;
    for (i = 0; i < pat.len(); i++)
    begin
        @(negedge clk);
        isstring  = 1'b0;
        ispattern = 1'b1;
        chardata  = pat[i];
        if (pat[i] == HEAD_ANCHOR)
            mdl_head = 1'b1;
        else if (pat[i] == TAIL_ANCHOR)
            mdl_tail = 1'b1;
        else
        begin
            mdl_pat[mdl_plen] = pat[i];
            mdl_plen++;
        end
    end
    @(negedge clk);
    isstring  = 1'b0;
    ispattern = 1'b0;
    chardata  = '0;
    waited    = 0;
    while (!valid && waited < VALID_WAIT)
    begin
        @(negedge clk);
        waited++;
    end
    if (!valid)
    begin
        $display("No valid within %0d cycles for pattern %s", VALID_WAIT, pat);
        $display("Simulation FAILED");
        $fatal(1);
    end
    got_match = match;
    got_idx   = match_index;
    exp_idx   = model_match();
    check(got_match, (exp_idx >= 0), {"match flag for ", pat});
    check(got_idx, (exp_idx >= 0) ? exp_idx : 0, {"match_index for ", pat});
endtask

task automatic literal_match();
    run_job(1'b1, "xxabyab", "ab");
    check(got_match, 1, "ab in xxabyab");
    check(got_idx, 2, "index of ab");
    run_job(1'b1, "xxabyab", "abz");
    check(got_match, 0, "abz absent");
    check(got_idx, 0, "index when absent");
endtask

task automatic wildcard_match();
    run_job(1'b1, "zzabcq", "a.c");
    check(got_idx, 2, "a.c in zzabcq");
    run_job(1'b1, "zzabcq", "cq..");
    check(got_match, 0, "pattern past the string end");
endtask

task automatic head_anchor_match();
    run_job(1'b1, "concat_cat", "^cat");
    check(got_idx, 7, "^cat in concat_cat");
    run_job(1'b1, "concat_cat", "^con");
    check(got_idx, 0, "^con in concat_cat");
endtask

task automatic tail_anchor_match();
    run_job(1'b1, "cats_bat", "at$");
    check(got_idx, 6, "at$ in cats_bat");
    run_job(1'b1, "bat_batx_bat", "^bat$");
    check(got_idx, 0, "^bat$ in bat_batx_bat");
    run_job(1'b1, "xbat_bat", "^bat$");
    check(got_idx, 5, "^bat$ in xbat_bat");
endtask

task automatic string_reuse();
    run_job(1'b1, "ab_cd_ab", "cd");
    check(got_idx, 3, "cd in ab_cd_ab");
    run_job(1'b0, "", "d$");
    check(got_idx, 4, "d$ against the kept string");
endtask

function automatic byte random_char(input bit with_wild);
    int r;
    r = $unsigned($random(seed)) % (with_wild ? 4 : 3);
    case (r)
        0: return "a";
        1: return "b";
        2: return "_";
        default: return ".";
    endcase
endfunction

task automatic random_jobs();
    int j;
    int i;
    int slen;
    int plen;
    bit new_str;
    string s;
    string pat;
    for (j = 0; j < 40; j++)
    begin
        // roughly one job in four keeps the old string
        new_str = (j == 0) || (($random(seed) & 3) != 0);
        s = "";
        if (new_str)
        begin
            slen = 1 + ($random(seed) & 15);
            for (i = 0; i < slen; i++)
                s = $sformatf("%s%c", s, random_char(1'b0));
        end
        plen = 1 + ($random(seed) & 3);
        pat  = "";
        if (($random(seed) & 3) == 0)
            pat = "^";
        for (i = 0; i < plen; i++)
            pat = $sformatf("%s%c", pat, random_char(1'b1));
        if (($random(seed) & 3) == 0)
            pat = {pat, "$"};
        run_job(new_str, s, pat);
    end
endtask

//--- bench/sme_tb.sv
module sme_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import sme_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_JOBS     = 51;
    localparam int CYCLES_PER_JOB = 50;
    localparam int VALID_WAIT   = 34;

    logic     clk;
    logic     reset;
    char_t    chardata;
    logic     isstring;
    logic     ispattern;
    logic     valid;
    logic     match;
    str_idx_t match_index;

    integer   seed;

    // reference copy of the job the DUT is working on
    byte      mdl_str [STR_DEPTH];
    int       mdl_len;
    byte      mdl_pat [PAT_DEPTH];
    int       mdl_plen;
    bit       mdl_head;
    bit       mdl_tail;

    // last result seen on valid
    logic     got_match;
    str_idx_t got_idx;

    sme_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .chardata    (chardata),
        .isstring    (isstring),
        .ispattern   (ispattern),
        .valid       (valid),
        .match       (match),
        .match_index (match_index)
    );

    `include "sme_tb_tasks.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial
    begin
        #((NUM_JOBS * CYCLES_PER_JOB + RESET_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("Simulation FAILED");
        $fatal(1);
    end

    initial
    begin
        clk       = 1'b0;
        reset     = 1'b1;
        chardata  = '0;
        isstring  = 1'b0;
        ispattern = 1'b0;
        seed      = 94159;
        mdl_len   = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check(valid, 0, "valid after reset");
        check(match, 0, "match after reset");
        check(match_index, 0, "match_index after reset");

        literal_match();
        wildcard_match();
        head_anchor_match();
        tail_anchor_match();
        string_reuse();
        random_jobs();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- common/sme_pkg.sv
package sme_pkg;

    // capacities
    localparam int STR_DEPTH = 32;
    localparam int PAT_DEPTH = 8;

    typedef logic [7:0] char_t;

    // position in the string, also addresses the pattern store
    typedef logic [4:0] str_idx_t;

    // lengths need one more bit than the index
    typedef logic [5:0] str_len_t;
    typedef logic [3:0] pat_len_t;

    // pattern control characters
    localparam char_t HEAD_ANCHOR = 8'h5e;
    localparam char_t TAIL_ANCHOR = 8'h24;
    localparam char_t WILDCARD    = 8'h2e;

    // word boundary inside the string
    localparam char_t SEPARATOR   = 8'h5f;

    // one store write
    typedef struct packed {
        logic     en;
        str_idx_t addr;
        char_t    data;
    } store_wr_t;

    // what the matcher needs to know about a job
    typedef struct packed {
        str_len_t str_len;
        pat_len_t pat_len;
        logic     head_anchor;
        logic     tail_anchor;
    } sme_job_t;

endpackage

//--- matcher/sme_matcher.sv
module sme_matcher (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      start,
    input  sme_pkg::sme_job_t                         job,
    input  sme_pkg::char_t [sme_pkg::STR_DEPTH-1:0]   str_chars,
    input  sme_pkg::char_t [sme_pkg::PAT_DEPTH-1:0]   pat_chars,
    output logic                                      busy,
    output logic                                      valid,
    output logic                                      match,
    output sme_pkg::str_idx_t                         match_index
);
    import sme_pkg::*;

    typedef enum logic [1:0] {
        M_IDLE,
        M_SCAN,
        M_REPORT
    } m_state_t;

    m_state_t             state;
    str_idx_t             pos;
    str_len_t             pos_ext;
    str_len_t             tail_idx;
    logic [PAT_DEPTH-1:0] hit_map;
    logic                 head_ok;
    logic                 tail_ok;
    logic                 pos_hit;
    logic                 last_pos;

    assign pos_ext  = {1'b0, pos};
    // first string position after the window
    assign tail_idx = pos_ext + str_len_t'(job.pat_len);

    // window compare at the current start position
    always_comb
    begin
        str_len_t sidx;
        logic     in_str;

        for (int k = 0; k < PAT_DEPTH; k++)
        begin
            sidx   = pos_ext + str_len_t'(k);
            in_str = (sidx < job.str_len);
            if (pat_len_t'(k) >= job.pat_len)
            begin
                // unused pattern slots always pass
                hit_map[k] = 1'b1;
            end
            else if (!in_str)
            begin
                hit_map[k] = 1'b0;
            end
            else
            begin
                hit_map[k] = (pat_chars[k] == WILDCARD)
                             || (pat_chars[k] == str_chars[str_idx_t'(sidx)]);
            end
        end
    end

    // '^' needs the start of the string or a separator before the window
    assign head_ok = !job.head_anchor || (pos == '0)
                     || (str_chars[str_idx_t'(pos - 1'b1)] == SEPARATOR);

    // '$' needs the end of the string or a separator right after it
    assign tail_ok = !job.tail_anchor || (tail_idx == job.str_len)
                     || ((tail_idx < job.str_len)
                         && (str_chars[str_idx_t'(tail_idx)] == SEPARATOR));

    assign pos_hit  = (&hit_map) && head_ok && tail_ok;
    assign last_pos = (pos_ext + 1'b1 >= job.str_len);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state       <= M_IDLE;
            pos         <= '0;
            match       <= 1'b0;
            match_index <= '0;
        end
        else
        begin
            case (state)
                M_IDLE:
                begin
                    if (start)
                    begin
                        state <= M_SCAN;
                        pos   <= '0;
                    end
                end
                M_SCAN:
                begin
                    if (pos_hit || last_pos)
                    begin
                        state       <= M_REPORT;
                        match       <= pos_hit;
                        match_index <= pos_hit ? pos : '0;
                    end
                    else
                    begin
                        pos <= pos + 1'b1;
                    end
                end
                M_REPORT:
                begin
                    state <= M_IDLE;
                end
                default:
                begin
                    state <= M_IDLE;
                end
            endcase
        end
    end

    // result is already registered when valid rises
    assign valid = (state == M_REPORT);
    assign busy  = (state != M_IDLE);

endmodule

//--- verilog.f
+incdir+bench
common/sme_pkg.sv
verilog/sme_char_store.sv
verilog/sme_loader.sv
matcher/sme_matcher.sv
verilog/sme_top.sv
bench/sme_tb.sv

//--- verilog/sme_char_store.sv
module sme_char_store #(
    parameter int DEPTH = sme_pkg::STR_DEPTH
) (
    input  logic                           clk,
    input  logic                           reset,
    input  sme_pkg::store_wr_t             wr,
    output sme_pkg::char_t [DEPTH-1:0]     contents
);
    import sme_pkg::*;

    // one write port, every entry readable at once
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            contents <= '0;
        end
        else
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                // addresses past the depth are simply not stored
                if (wr.en && (wr.addr == str_idx_t'(i)))
                begin
                    contents[i] <= wr.data;
                end
            end
        end
    end

endmodule

//--- verilog/sme_loader.sv
module sme_loader (
    input  logic               clk,
    input  logic               reset,
    input  sme_pkg::char_t     chardata,
    input  logic               isstring,
    input  logic               ispattern,
    input  logic               busy,
    output sme_pkg::store_wr_t str_wr,
    output sme_pkg::store_wr_t pat_wr,
    output sme_pkg::sme_job_t  job,
    output logic               start
);
    import sme_pkg::*;

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_STRING,
        LD_PATTERN
    } ld_state_t;

    ld_state_t state;
    logic      accept;
    logic      str_char;
    logic      pat_char;
    logic      is_head;
    logic      is_tail;
    logic      head_base;
    logic      tail_base;
    str_len_t  str_base;
    pat_len_t  pat_base;

    // strobes are dropped while a job is pending or running
    assign accept   = !busy && !start;
    assign str_char = accept && isstring;
    assign pat_char = accept && !isstring && ispattern;

    assign is_head = (chardata == HEAD_ANCHOR);
    assign is_tail = (chardata == TAIL_ANCHOR);

    // a new run restarts its own length and flags
    assign str_base  = (state == LD_STRING) ? job.str_len : '0;
    assign pat_base  = (state == LD_PATTERN) ? job.pat_len : '0;
    assign head_base = (state == LD_PATTERN) && job.head_anchor;
    assign tail_base = (state == LD_PATTERN) && job.tail_anchor;

    always_comb
    begin
        str_wr.en   = str_char && (str_base < str_len_t'(STR_DEPTH));
        str_wr.addr = str_idx_t'(str_base);
        str_wr.data = chardata;
        // anchors become flags and never reach the store
        pat_wr.en   = pat_char && !is_head && !is_tail && (pat_base < pat_len_t'(PAT_DEPTH));
        pat_wr.addr = str_idx_t'(pat_base);
        pat_wr.data = chardata;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= LD_IDLE;
            job   <= '0;
            start <= 1'b0;
        end
        else
        begin
            start <= 1'b0;
            if (str_char)
            begin
                state       <= LD_STRING;
                job.str_len <= str_wr.en ? str_base + 1'b1 : str_base;
            end
            else if (pat_char)
            begin
                state           <= LD_PATTERN;
                job.pat_len     <= pat_wr.en ? pat_base + 1'b1 : pat_base;
                job.head_anchor <= head_base || is_head;
                job.tail_anchor <= tail_base || is_tail;
            end
            else if (state == LD_PATTERN)
            begin
                // end of the pattern run kicks off the scan
                state <= LD_IDLE;
                start <= 1'b1;
            end
            else
            begin
                state <= LD_IDLE;
            end
        end
    end

endmodule

//--- verilog/sme_top.sv
module sme_top (
    input  logic              clk,
    input  logic              reset,
    input  sme_pkg::char_t    chardata,
    input  logic              isstring,
    input  logic              ispattern,
    output logic              valid,
    output logic              match,
    output sme_pkg::str_idx_t match_index
);
    import sme_pkg::*;

    store_wr_t             str_wr;
    store_wr_t             pat_wr;
    sme_job_t              job;
    logic                  start;
    logic                  busy;
    char_t [STR_DEPTH-1:0] str_chars;
    char_t [PAT_DEPTH-1:0] pat_chars;

    sme_loader loader (
        .clk       (clk),
        .reset     (reset),
        .chardata  (chardata),
        .isstring  (isstring),
        .ispattern (ispattern),
        .busy      (busy),
        .str_wr    (str_wr),
        .pat_wr    (pat_wr),
        .job       (job),
        .start     (start)
    );

    sme_char_store #(
        .DEPTH (STR_DEPTH)
    ) string_store (
        .clk      (clk),
        .reset    (reset),
        .wr       (str_wr),
        .contents (str_chars)
    );

    sme_char_store #(
        .DEPTH (PAT_DEPTH)
    ) pattern_store (
        .clk      (clk),
        .reset    (reset),
        .wr       (pat_wr),
        .contents (pat_chars)
    );

    sme_matcher matcher (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .job         (job),
        .str_chars   (str_chars),
        .pat_chars   (pat_chars),
        .busy        (busy),
        .valid       (valid),
        .match       (match),
        .match_index (match_index)
    );

endmodule
